// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLL  = 4'd2;
    localparam logic [3:0] ALU_SLT  = 4'd3;
    localparam logic [3:0] ALU_SLTU = 4'd4;
    localparam logic [3:0] ALU_XOR  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_OR   = 4'd8;
    localparam logic [3:0] ALU_AND  = 4'd9;

    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_PC4 = 2'd1; // Link address for jumps
    localparam logic [1:0] RES_IMM = 2'd2; // LUI

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

`default_nettype wire

// File: rtl/de_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface de_ctrl_if;

    logic       jump;
    logic       branch;
    logic       alu_src_a;
    logic       alu_src_b;
    logic       reg_write;
    logic       pc_target_src;
    logic [1:0] result_src;
    logic [2:0] funct3;
    logic [3:0] alu_control;
    logic       valid;

    modport reg_mp (
        output jump, branch, alu_src_a, alu_src_b, reg_write, pc_target_src,
        output result_src, funct3, alu_control, valid
    );

    modport exe_mp (
        input jump, branch, alu_src_a, alu_src_b, reg_write, pc_target_src,
        input result_src, funct3, alu_control, valid
    );

endinterface

`default_nettype wire

// File: rtl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_pkg::*; (
    input  instr_u                instr_i,
    input  logic                  instr_valid_i,
    output logic                  jump_o,
    output logic                  branch_o,
    output logic                  alu_src_a_o,
    output logic                  alu_src_b_o,
    output logic                  reg_write_o,
    output logic                  pc_target_src_o,
    output logic [1:0]            result_src_o,
    output logic [2:0]            funct3_o,
    output logic [3:0]            alu_control_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  valid_o
);

    logic [6:0] opcode;
    logic       write_en;

    function automatic logic [3:0] alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i.r.opcode;
    assign rs1_o  = instr_i.r.rs1;
    assign rs2_o  = instr_i.r.rs2;
    assign rd_o   = instr_i.r.rd;

    always_comb begin
        jump_o          = 1'b0;
        branch_o        = 1'b0;
        alu_src_a_o     = 1'b0;
        alu_src_b_o     = 1'b0;
        pc_target_src_o = 1'b0;
        result_src_o    = RES_ALU;
        alu_control_o   = ALU_ADD;
        imm_o           = '0;
        write_en        = 1'b0;
        valid_o         = instr_valid_i;
        if (instr_valid_i) begin
            case (opcode)
                OP_R: begin
                    write_en      = 1'b1;
                    alu_control_o = alu_op(instr_i.r.funct3, instr_i.r.funct7[5]);
                end
                OP_IMM: begin
                    write_en      = 1'b1;
                    alu_src_b_o   = 1'b1;
                    imm_o         = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
                    // Only SRAI carries a function bit in the upper field
                    alu_control_o = alu_op(instr_i.i.funct3,
                                           instr_i.i.funct3 == 3'b101 && instr_i.r.funct7[5]);
                end
                OP_LUI: begin
                    write_en     = 1'b1;
                    result_src_o = RES_IMM;
                    imm_o        = {instr_i.u.imm_31_12, 12'b0};
                end
                OP_AUIPC: begin
                    write_en    = 1'b1;
                    alu_src_a_o = 1'b1; // PC + imm
                    alu_src_b_o = 1'b1;
                    imm_o       = {instr_i.u.imm_31_12, 12'b0};
                end
                OP_JAL: begin
                    write_en     = 1'b1;
                    jump_o       = 1'b1;
                    result_src_o = RES_PC4;
                    imm_o        = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                                    instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
                end
                OP_JALR: begin
                    write_en        = 1'b1;
                    jump_o          = 1'b1;
                    pc_target_src_o = 1'b1;
                    result_src_o    = RES_PC4;
                    imm_o           = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
                end
                OP_BRANCH: begin
                    branch_o = 1'b1;
                    imm_o    = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                                instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
                end
                default: valid_o = 1'b0; // Unsupported opcode becomes a bubble
            endcase
        end
        funct3_o    = valid_o ? instr_i.r.funct3 : 3'b000;
        reg_write_o = write_en && (instr_i.r.rd != '0);
    end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       wd_i,
    output logic [XLEN-1:0]       rd1_o,
    output logic [XLEN-1:0]       rd2_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 2**REG_ADDR_W; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Same-cycle write is forwarded to the readers
    assign rd1_o = (rs1_i == '0)                ? '0   :
                   (we_i && rd_i == rs1_i)      ? wd_i :
                                                  regs[rs1_i];
    assign rd2_o = (rs2_i == '0)                ? '0   :
                   (we_i && rd_i == rs2_i)      ? wd_i :
                                                  regs[rs2_i];

endmodule

`default_nettype wire

// File: rtl/pipeline_control_reg_de.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control_reg_de (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clr_i,
    input  logic       jump_d_i,
    input  logic       branch_d_i,
    input  logic       alu_src_a_d_i,
    input  logic       alu_src_b_d_i,
    input  logic       reg_write_d_i,
    input  logic       pc_target_src_d_i,
    input  logic [1:0] result_src_d_i,
    input  logic [2:0] funct3_d_i,
    input  logic [3:0] alu_control_d_i,
    input  logic       valid_d_i,
    de_ctrl_if.reg_mp  ctrl
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl.jump          <= 1'b0;
            ctrl.branch        <= 1'b0;
            ctrl.alu_src_a     <= 1'b0;
            ctrl.alu_src_b     <= 1'b0;
            ctrl.reg_write     <= 1'b0;
            ctrl.pc_target_src <= 1'b0;
            ctrl.result_src    <= '0;
            ctrl.funct3        <= '0;
            ctrl.alu_control   <= '0;
            ctrl.valid         <= 1'b0;
        end else if (clr_i) begin // Flush inserts a bubble
            ctrl.jump          <= 1'b0;
            ctrl.branch        <= 1'b0;
            ctrl.alu_src_a     <= 1'b0;
            ctrl.alu_src_b     <= 1'b0;
            ctrl.reg_write     <= 1'b0;
            ctrl.pc_target_src <= 1'b0;
            ctrl.result_src    <= '0;
            ctrl.funct3        <= '0;
            ctrl.alu_control   <= '0;
            ctrl.valid         <= 1'b0;
        end else begin
            ctrl.jump          <= jump_d_i;
            ctrl.branch        <= branch_d_i;
            ctrl.alu_src_a     <= alu_src_a_d_i;
            ctrl.alu_src_b     <= alu_src_b_d_i;
            ctrl.reg_write     <= reg_write_d_i;
            ctrl.pc_target_src <= pc_target_src_d_i;
            ctrl.result_src    <= result_src_d_i;
            ctrl.funct3        <= funct3_d_i;
            ctrl.alu_control   <= alu_control_d_i;
            ctrl.valid         <= valid_d_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pipeline_data_reg_de.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_data_reg_de import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       rd1_i,
    input  logic [XLEN-1:0]       rd2_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    output logic [XLEN-1:0]       rd1_o,
    output logic [XLEN-1:0]       rd2_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [REG_ADDR_W-1:0] rd_o
);

    // A flushed entry is neutralized by the cleared control bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd1_o <= '0;
            rd2_o <= '0;
            imm_o <= '0;
            pc_o  <= '0;
            rd_o  <= '0;
        end else begin
            rd1_o <= rd1_i;
            rd2_o <= rd2_i;
            imm_o <= imm_i;
            pc_o  <= pc_i;
            rd_o  <= rd_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_pkg::*; (
    de_ctrl_if.exe_mp             ctrl,
    input  logic [XLEN-1:0]       rd1_i,
    input  logic [XLEN-1:0]       rd2_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] target_base;
    logic [XLEN-1:0] target_sum;
    logic [XLEN-1:0] pc_plus4;
    logic            taken;

    assign src_a = ctrl.alu_src_a ? pc_i : rd1_i;
    assign src_b = ctrl.alu_src_b ? imm_i : rd2_i;

    always_comb begin
        case (ctrl.alu_control)
            ALU_ADD:  alu_result = src_a + src_b;
            ALU_SUB:  alu_result = src_a - src_b;
            ALU_SLL:  alu_result = src_a << src_b[4:0];
            ALU_SLT:  alu_result = XLEN'($signed(src_a) < $signed(src_b));
            ALU_SLTU: alu_result = XLEN'(src_a < src_b);
            ALU_XOR:  alu_result = src_a ^ src_b;
            ALU_SRL:  alu_result = src_a >> src_b[4:0];
            ALU_SRA:  alu_result = $signed(src_a) >>> src_b[4:0];
            ALU_OR:   alu_result = src_a | src_b;
            ALU_AND:  alu_result = src_a & src_b;
            default:  alu_result = '0;
        endcase
    end

    // Branch compare always works on the two register operands
    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = (rd1_i == rd2_i);
            3'b001:  taken = (rd1_i != rd2_i);
            3'b100:  taken = ($signed(rd1_i) < $signed(rd2_i));
            3'b101:  taken = ($signed(rd1_i) >= $signed(rd2_i));
            3'b110:  taken = (rd1_i < rd2_i);
            3'b111:  taken = (rd1_i >= rd2_i);
            default: taken = 1'b0;
        endcase
    end

    assign target_base   = ctrl.pc_target_src ? rd1_i : pc_i; // JALR uses rs1
    assign target_sum    = target_base + imm_i;
    assign redirect_pc_o = {target_sum[XLEN-1:1], target_sum[0] & ~ctrl.pc_target_src};
    assign redirect_o    = ctrl.jump | (ctrl.branch & taken);

    assign pc_plus4 = pc_i + XLEN'(4);

    always_comb begin
        case (ctrl.result_src)
            RES_PC4: wb_data_o = pc_plus4;
            RES_IMM: wb_data_o = imm_i;
            default: wb_data_o = alu_result;
        endcase
    end

    assign wb_en_o = ctrl.reg_write & ctrl.valid;
    assign wb_rd_o = rd_i;

endmodule

`default_nettype wire

// File: rtl/rv_core_de.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_de import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       instr_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  instr_valid_i,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic                  jump_d;
    logic                  branch_d;
    logic                  alu_src_a_d;
    logic                  alu_src_b_d;
    logic                  reg_write_d;
    logic                  pc_target_src_d;
    logic [1:0]            result_src_d;
    logic [2:0]            funct3_d;
    logic [3:0]            alu_control_d;
    logic                  valid_d;
    logic [REG_ADDR_W-1:0] rs1_d;
    logic [REG_ADDR_W-1:0] rs2_d;
    logic [REG_ADDR_W-1:0] rd_d;
    logic [XLEN-1:0]       imm_d;
    logic [XLEN-1:0]       rd1_d;
    logic [XLEN-1:0]       rd2_d;
    logic [XLEN-1:0]       rd1_e;
    logic [XLEN-1:0]       rd2_e;
    logic [XLEN-1:0]       imm_e;
    logic [XLEN-1:0]       pc_e;
    logic [REG_ADDR_W-1:0] rd_e;

    de_ctrl_if ctrl_e ();

    decode_unit u_decode (
        .instr_i(instr_i), .instr_valid_i(instr_valid_i),
        .jump_o(jump_d), .branch_o(branch_d),
        .alu_src_a_o(alu_src_a_d), .alu_src_b_o(alu_src_b_d),
        .reg_write_o(reg_write_d), .pc_target_src_o(pc_target_src_d),
        .result_src_o(result_src_d), .funct3_o(funct3_d), .alu_control_o(alu_control_d),
        .rs1_o(rs1_d), .rs2_o(rs2_d), .rd_o(rd_d), .imm_o(imm_d), .valid_o(valid_d)
    );

    register_file u_regfile (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .rs1_i(rs1_d), .rs2_i(rs2_d),
        .we_i(wb_en_o), .rd_i(wb_rd_o), .wd_i(wb_data_o), // Writeback from E
        .rd1_o(rd1_d), .rd2_o(rd2_d)
    );

    pipeline_control_reg_de u_ctrl_reg (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .clr_i(redirect_o),
        .jump_d_i(jump_d), .branch_d_i(branch_d),
        .alu_src_a_d_i(alu_src_a_d), .alu_src_b_d_i(alu_src_b_d),
        .reg_write_d_i(reg_write_d), .pc_target_src_d_i(pc_target_src_d),
        .result_src_d_i(result_src_d), .funct3_d_i(funct3_d),
        .alu_control_d_i(alu_control_d), .valid_d_i(valid_d),
        .ctrl(ctrl_e.reg_mp)
    );

    pipeline_data_reg_de u_data_reg (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .rd1_i(rd1_d), .rd2_i(rd2_d), .imm_i(imm_d), .pc_i(pc_i), .rd_i(rd_d),
        .rd1_o(rd1_e), .rd2_o(rd2_e), .imm_o(imm_e), .pc_o(pc_e), .rd_o(rd_e)
    );

    execute_stage u_execute (
        .ctrl(ctrl_e.exe_mp),
        .rd1_i(rd1_e), .rd2_i(rd2_e), .imm_i(imm_e), .pc_i(pc_e), .rd_i(rd_e),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o),
        .wb_en_o(wb_en_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

endmodule

`default_nettype wire

// File: sim/rv_core_de_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_de_asserts import rv_pkg::*; (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  instr_valid_i,
    input logic                  redirect_o,
    input logic                  wb_en_o,
    input logic [REG_ADDR_W-1:0] wb_rd_o
);

    int unsigned fail_count = 0; // Failed assertions so far
    logic        seen_valid;     // Set once a valid instruction has been sampled in D

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            seen_valid <= 1'b0;
        end else if (instr_valid_i) begin
            seen_valid <= 1'b1;
        end
    end

    quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !seen_valid |-> !redirect_o && !wb_en_o)
        else begin
            fail_count++;
            $error("redirect_o or wb_en_o high before a valid instruction reached E");
        end

    no_write_to_x0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_en_o |-> wb_rd_o != '0)
        else begin
            fail_count++;
            $error("wb_en_o high with wb_rd_o equal to x0");
        end

    // The instruction behind a redirect must come out as a bubble
    flush_after_redirect: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_o |=> !redirect_o && !wb_en_o)
        else begin
            fail_count++;
            $error("Squashed instruction was not cleared after a redirect");
        end

endmodule

bind rv_core_de rv_core_de_asserts u_asserts (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i),
    .redirect_o(redirect_o),
    .wb_en_o(wb_en_o),
    .wb_rd_o(wb_rd_o)
);

`default_nettype wire

// File: sim/tb_rv_core_de.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core_de import rv_pkg::*; ();

    localparam logic [31:0] SEED           = 32'hfa1fd4f7;
    localparam int          N_INSTR        = 400;
    localparam int          TIMEOUT_CYCLES = N_INSTR * 2 + 50;

    logic                  clk_i;
    logic                  rst_n_i;
    logic [XLEN-1:0]       instr_i;
    logic [XLEN-1:0]       pc_i;
    logic                  instr_valid_i;
    logic                  redirect_o;
    logic [XLEN-1:0]       redirect_pc_o;
    logic                  wb_en_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;

    logic [31:0]           lfsr_state;
    logic [XLEN-1:0]       gold [32]; // Architectural register state in program order
    instr_u                word;
    int                    errors;
    int                    cycle_count = 0;

    // What E must show for the instruction issued in the previous cycle
    logic                  exp_wb_en;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]       exp_data;
    logic                  exp_redirect;
    logic [XLEN-1:0]       exp_target;

    rv_core_de rv_core_de_inst (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .instr_i(instr_i),
        .pc_i(pc_i),
        .instr_valid_i(instr_valid_i),
        .redirect_o(redirect_o),
        .redirect_pc_o(redirect_pc_o),
        .wb_en_o(wb_en_o),
        .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the instruction stream never finished",
                     cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] golden_alu(input logic [2:0] f3, input logic alt,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic set_bubble();
        exp_wb_en    = 1'b0;
        exp_rd       = '0;
        exp_data     = '0;
        exp_redirect = 1'b0;
        exp_target   = '0;
    endtask

    // Encodes one random instruction and works out its effect from the ISA rules
    task automatic build_instr(input logic [XLEN-1:0] pc, input logic commit);
        logic [2:0]            kind;
        logic [2:0]            f3;
        logic                  alt;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [11:0]           raw12;
        logic [19:0]           raw20;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic                  writes;
        kind  = 3'(take_bits(3));
        rd    = 5'(take_bits(3)); // x0..x7 so dependencies and x0 come up often
        rs1   = 5'(take_bits(3));
        rs2   = 5'(take_bits(3));
        f3    = 3'(take_bits(3));
        alt   = 1'(take_bits(1));
        raw12 = 12'(take_bits(12));
        raw20 = 20'(take_bits(20));
        a     = gold[rs1];
        b     = gold[rs2];
        word  = '0;
        writes       = 1'b1;
        exp_data     = '0;
        exp_redirect = 1'b0;
        exp_target   = '0;
        case (kind)
            3'd0, 3'd1: begin
                alt            = alt && (f3 == 3'b000 || f3 == 3'b101);
                word.r.opcode  = OP_R;
                word.r.rd      = rd;
                word.r.funct3  = f3;
                word.r.rs1     = rs1;
                word.r.rs2     = rs2;
                word.r.funct7  = {1'b0, alt, 5'b0};
                exp_data       = golden_alu(f3, alt, a, b);
            end
            3'd2, 3'd3: begin
                word.i.opcode = OP_IMM;
                word.i.rd     = rd;
                word.i.funct3 = f3;
                word.i.rs1    = rs1;
                if (f3 == 3'b001 || f3 == 3'b101) begin // Shifts take a 5 bit shamt
                    alt             = alt && f3 == 3'b101;
                    imm             = {27'b0, raw12[4:0]};
                    word.i.imm_11_0 = {1'b0, alt, 5'b0, raw12[4:0]};
                end else begin
                    alt             = 1'b0;
                    imm             = {{20{raw12[11]}}, raw12};
                    word.i.imm_11_0 = raw12;
                end
                exp_data = golden_alu(f3, alt, a, imm);
            end
            3'd4: begin
                imm              = {raw20, 12'b0};
                word.u.opcode    = alt ? OP_LUI : OP_AUIPC;
                word.u.rd        = rd;
                word.u.imm_31_12 = raw20;
                exp_data         = alt ? imm : pc + imm;
            end
            3'd5: begin
                if (f3[2:1] == 2'b01) begin
                    f3 = f3 ^ 3'b110; // 010 and 011 are not branches
                end
                imm             = {{19{raw12[11]}}, raw12, 1'b0};
                word.b.opcode   = OP_BRANCH;
                word.b.funct3   = f3;
                word.b.rs1      = rs1;
                word.b.rs2      = rs2;
                word.b.imm_12   = imm[12];
                word.b.imm_11   = imm[11];
                word.b.imm_10_5 = imm[10:5];
                word.b.imm_4_1  = imm[4:1];
                writes          = 1'b0;
                exp_redirect    = branch_taken(f3, a, b);
                exp_target      = pc + imm;
            end
            3'd6: begin
                imm              = {{11{raw20[19]}}, raw20, 1'b0};
                word.j.opcode    = OP_JAL;
                word.j.rd        = rd;
                word.j.imm_20    = imm[20];
                word.j.imm_19_12 = imm[19:12];
                word.j.imm_11    = imm[11];
                word.j.imm_10_1  = imm[10:1];
                exp_data         = pc + 32'd4;
                exp_redirect     = 1'b1;
                exp_target       = pc + imm;
            end
            default: begin
                imm             = {{20{raw12[11]}}, raw12};
                word.i.opcode   = OP_JALR;
                word.i.rd       = rd;
                word.i.funct3   = 3'b000;
                word.i.rs1      = rs1;
                word.i.imm_11_0 = raw12;
                exp_data        = pc + 32'd4;
                exp_redirect    = 1'b1;
                exp_target      = (a + imm) & ~32'd1;
            end
        endcase
        exp_rd    = rd;
        exp_wb_en = writes && rd != '0;
        if (commit && exp_wb_en) begin
            gold[rd] = exp_data;
        end
    endtask

    task automatic check_e();
        assert (redirect_o === exp_redirect)
            else log_mismatch($sformatf("redirect_o is %0b, expected %0b",
                                        redirect_o, exp_redirect));
        assert (wb_en_o === exp_wb_en)
            else log_mismatch($sformatf("wb_en_o is %0b, expected %0b", wb_en_o, exp_wb_en));
        if (exp_wb_en) begin
            assert (wb_rd_o === exp_rd)
                else log_mismatch($sformatf("wb_rd_o is x%0d, expected x%0d", wb_rd_o, exp_rd));
            assert (wb_data_o === exp_data)
                else log_mismatch($sformatf("wb_data_o for x%0d is %h, expected %h",
                                            exp_rd, wb_data_o, exp_data));
        end
        if (exp_redirect) begin
            assert (redirect_pc_o === exp_target)
                else log_mismatch($sformatf("redirect_pc_o is %h, expected %h",
                                            redirect_pc_o, exp_target));
        end
    endtask

    initial begin
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            squash_next;
        errors        = 0;
        lfsr_state    = SEED;
        rst_n_i       = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        instr_valid_i = 1'b0;
        pc            = 32'h0000_0100;
        target        = '0;
        squash_next   = 1'b0;
        for (int k = 0; k < 32; k++) begin
            gold[k] = '0;
        end
        set_bubble();
        repeat (5) @(posedge clk_i);
        #2 rst_n_i = 1'b1;
        repeat (3) begin // Idle cycles keep E empty
            @(posedge clk_i);
            #2;
            check_e();
        end
        for (int n = 0; n < N_INSTR; n++) begin
            @(posedge clk_i);
            #2;
            check_e();
            build_instr(pc, !squash_next);
            instr_i       = word;
            pc_i          = pc;
            instr_valid_i = 1'b1;
            if (squash_next) begin // Sits in D while E redirects
                set_bubble();
                squash_next = 1'b0;
                pc          = target;
            end else if (exp_redirect) begin
                squash_next = 1'b1;
                target      = exp_target;
                pc          = pc + 32'd4;
            end else begin
                pc = pc + 32'd4;
            end
        end
        @(posedge clk_i);
        #2;
        check_e();
        instr_valid_i = 1'b0;
        set_bubble();
        repeat (2) begin
            @(posedge clk_i);
            #2;
            check_e();
        end
        $display("Run finished with %0d testbench errors and %0d assertion errors",
                 errors, rv_core_de_inst.u_asserts.fail_count);
        if (errors == 0 && rv_core_de_inst.u_asserts.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/rv_pkg.sv
rtl/de_ctrl_if.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/pipeline_control_reg_de.sv
rtl/pipeline_data_reg_de.sv
rtl/execute_stage.sv
rtl/rv_core_de.sv
sim/rv_core_de_asserts.sv
sim/tb_rv_core_de.sv
